// ==== src.f ====
+incdir+test
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_core.sv
logic/sprite_dma.sv
logic/bus_arbiter.sv
logic/nes_cpu.sv
test/tb_nes_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
verilator --binary --timing --assert --top-module tb_nes_cpu -f src.f -o sim_nes_cpu \
   || { echo "build failed"; exit 1; }
./obj_dir/sim_nes_cpu > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// right-shift Galois LFSR
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
   return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// one LFSR step for every bit taken
function automatic logic [15:0] take_bits(input int count);
   logic [15:0] value;
   value = '0;
   for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
   end
   return value;
endfunction

// group one in immediate or absolute mode, STA only absolute
function automatic logic executes(input logic [7:0] opcode);
   return (opcode[1:0] == cpu_pkg::GROUP_ONE) &&
      (((opcode[4:2] == cpu_pkg::MODE_IMM) && (opcode[7:5] != 3'd4)) ||
       (opcode[4:2] == cpu_pkg::MODE_ABS));
endfunction

// next {flags, A} by the 6502 rules
function automatic logic [11:0] ref_exec(input logic [7:0] opcode, input logic [7:0] operand,
                                         input logic [7:0] a, input cpu_pkg::flags_t flags);
   cpu_pkg::flags_t f;
   logic [7:0]      r;
   logic [7:0]      diff;
   int              wide;
   int              signed_sum;
   f    = flags;
   r    = a;
   diff = a - operand;
   if (executes(opcode)) begin
      case (opcode[7:5])
         3'd0: r = a | operand;
         3'd1: r = a & operand;
         3'd2: r = a ^ operand;
         3'd3: begin
            wide       = int'(a) + int'(operand) + int'(flags.c);
            signed_sum = int'($signed(a)) + int'($signed(operand)) + int'(flags.c);
            r   = wide[7:0];
            f.c = (wide > 255);
            f.v = (signed_sum > 127) || (signed_sum < -128);
         end
         3'd5: r = operand;
         3'd6: begin
            f.c = (a >= operand);
            f.n = diff[7];
            f.z = (a == operand);
         end
         3'd7: begin
            // borrow is the inverted carry
            wide       = int'(a) - int'(operand) - int'(!flags.c);
            signed_sum = int'($signed(a)) - int'($signed(operand)) - int'(!flags.c);
            r   = wide[7:0];
            f.c = (wide >= 0);
            f.v = (signed_sum > 127) || (signed_sum < -128);
         end
         default: ;
      endcase
      if ((opcode[7:5] != 3'd4) && (opcode[7:5] != 3'd6)) begin
         f.n = r[7];
         f.z = (r == 8'h00);
      end
   end
   return {f, r};
endfunction

task automatic put_byte(input logic [7:0] value);
   mem[gen_pc] = value;
   gen_pc = gen_pc + 16'd1;
endtask

task automatic emit_op(input logic [2:0] aaa, input logic absolute, input logic [7:0] operand);
   logic [7:0]  opcode;
   logic [15:0] where;
   opcode = {aaa, absolute ? cpu_pkg::MODE_ABS : cpu_pkg::MODE_IMM, cpu_pkg::GROUP_ONE};
   put_byte(opcode);
   if (absolute) begin
      // each instruction owns a 16-byte slot of operand data
      where = {4'h1, n_instr[7:0], 4'h0} | take_bits(4);
      mem[where] = operand;
      put_byte(where[7:0]);
      put_byte(where[15:8]);
   end else begin
      put_byte(operand);
   end
   {model_flags, model_a} = ref_exec(opcode, operand, model_a, model_flags);
   n_instr++;
endtask

task automatic emit_sta(input logic [15:0] where);
   put_byte({3'd4, cpu_pkg::MODE_ABS, cpu_pkg::GROUP_ONE});
   put_byte(where[7:0]);
   put_byte(where[15:8]);
   exp_addr.push_back(where);
   exp_data.push_back(model_a);
   n_instr++;
endtask

function automatic logic [7:0] random_nop();
   logic [7:0] opcode;
   opcode = 8'(take_bits(8));
   while (executes(opcode)) begin
      opcode = 8'(take_bits(8));
   end
   return opcode;
endfunction

task automatic emit_nop(input logic [7:0] opcode);
   put_byte(opcode);
   {model_flags, model_a} = ref_exec(opcode, 8'h00, model_a, model_flags);
   n_instr++;
endtask

task automatic build_program();
   logic [1:0] pick;
   logic [2:0] aaa;
   gen_pc      = RESET_PC;
   model_a     = 8'h00;
   model_flags = '0;
   // logic ops and loads, immediate
   for (int i = 0; i < 8; i++) begin
      pick = 2'(take_bits(2));
      aaa  = (pick == 2'd3) ? 3'(cpu_pkg::ALU_LDA) : {1'b0, pick};
      emit_op(aaa, 1'b0, 8'(take_bits(8)));
      emit_sta(16'h0400 + 16'(n_instr));
   end
   // carry chains through ADC, SBC and CMP
   for (int i = 0; i < 12; i++) begin
      pick = 2'(take_bits(2));
      aaa  = (pick == 2'd0) ? 3'(cpu_pkg::ALU_CMP)
           : (pick[0] ? 3'(cpu_pkg::ALU_ADC) : 3'(cpu_pkg::ALU_SBC));
      emit_op(aaa, 1'b0, 8'(take_bits(8)));
      emit_sta(16'h0400 + 16'(n_instr));
   end
   for (int i = 0; i < 12; i++) begin
      aaa = 3'(take_bits(3));
      if (aaa == 3'(cpu_pkg::ALU_STA)) begin
         aaa = 3'(cpu_pkg::ALU_LDA);
      end
      emit_op(aaa, 1'b1, 8'(take_bits(8)));
      emit_sta(16'h0400 + 16'(n_instr));
   end
   // no-ops, the first one is STA immediate
   for (int i = 0; i < 6; i++) begin
      emit_op(3'(cpu_pkg::ALU_LDA), 1'b0, 8'(take_bits(8)));
      emit_nop((i == 0) ? 8'h89 : random_nop());
      emit_sta(16'h0400 + 16'(n_instr));
   end
   // sprite DMA of page 3
   emit_op(3'(cpu_pkg::ALU_LDA), 1'b0, 8'h03);
   emit_sta(cpu_pkg::DMA_TRIGGER_ADDR);
   for (int i = 0; i < 256; i++) begin
      exp_addr.push_back(cpu_pkg::SPRITE_PORT_ADDR);
      exp_data.push_back(mem[{8'h03, 8'(i)}]);
   end
   n_dma++;
   emit_op(3'(cpu_pkg::ALU_ADC), 1'b0, 8'(take_bits(8)));
   emit_sta(16'h0400 + 16'(n_instr));
   // idle tail
   repeat (8) put_byte(8'hea);
endtask

`endif

// ==== test/tb_nes_cpu.sv ====
`timescale 1ns/1ps

module tb_nes_cpu;

   localparam logic [15:0] RESET_PC = 16'hc000;
   localparam logic [31:0] SEED     = 32'hff26_8d71;

   logic           clock;
   logic           nreset;
   cpu_pkg::data_t data_in;
   cpu_pkg::addr_t addr;
   cpu_pkg::data_t data_out;
   logic           rw;

   // memory and the bus writes still to come
   logic [7:0]  mem [0:65535];
   logic [15:0] exp_addr[$];
   logic [7:0]  exp_data[$];

   logic [31:0]     lfsr_state;
   logic [15:0]     gen_pc;
   logic [7:0]      model_a;
   cpu_pkg::flags_t model_flags;
   int              n_instr;
   int              n_dma;
   int              cycles;
   int              limit;

   `include "tb_model.svh"

   nes_cpu #(
      .RESET_PC(RESET_PC)
   ) DUT (
      .clock   (clock),
      .nreset  (nreset),
      .data_in (data_in),
      .addr    (addr),
      .data_out(data_out),
      .rw      (rw)
   );

   always #5 clock = ~clock;

   // read data settles well before the next rising edge
   always @(negedge clock) begin
      data_in = mem[addr];
   end

   always @(posedge clock) begin
      if (!nreset && !rw) begin
         mem[addr] = data_out;
      end
   end

   // every bus write must match the head of the expected list
   always @(negedge clock) begin
      if (!nreset && !rw) begin
         assert (exp_addr.size() != 0)
            else begin
               $display("write of %h to %h at %0t ns was not expected", data_out, addr, $time);
               $display("Something failed");
               $fatal(1);
            end
         if (exp_addr.size() != 0) begin
            assert ((addr == exp_addr[0]) && (data_out == exp_data[0]))
               else begin
                  $display("ERROR at %0t ns: write of %h to %h, expected %h to %h",
                           $time, data_out, addr, exp_data[0], exp_addr[0]);
                  $display("Something failed");
                  $fatal(1);
               end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
         end
      end
   end

   always @(posedge clock) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("timeout, the program did not finish within %0d cycles", limit);
         $display("Something failed");
         $fatal(1);
      end
   end

   initial begin
      clock      = 1'b0;
      nreset     = 1'b1;
      data_in    = 8'h00;
      lfsr_state = SEED;
      n_instr    = 0;
      n_dma      = 0;
      cycles     = 0;
      for (int i = 0; i < 65536; i++) begin
         mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;
      end
      build_program();
      limit = 4 * n_instr + 512 * n_dma + 100;
      repeat (2) @(negedge clock);
      nreset = 1'b0;
      while (exp_addr.size() != 0) begin
         @(negedge clock);
      end
      // no-op tail, any write here is caught by the checker
      repeat (6) @(negedge clock);
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== logic/nes_cpu.sv ====
`timescale 1ns/1ps

module nes_cpu #(
   parameter cpu_pkg::addr_t RESET_PC = 16'h8000
) (
   input                  clock,
   input                  nreset,
   input  cpu_pkg::data_t data_in,
   output cpu_pkg::addr_t addr,
   output cpu_pkg::data_t data_out,
   output logic           rw
);

   cpu_pkg::bus_req_t cpu_req;
   cpu_pkg::bus_req_t dma_req;
   logic              cpu_ready;
   logic              dma_grant;

   cpu_core #(
      .RESET_PC(RESET_PC)
   ) core (
      .clock    (clock),
      .nreset   (nreset),
      .data_in  (data_in),
      .cpu_ready(cpu_ready),
      .cpu_req  (cpu_req)
   );

   // watches the arbiter's own bus outputs for the trigger write
   sprite_dma dma (
      .clock    (clock),
      .nreset   (nreset),
      .bus_addr (addr),
      .bus_data (data_out),
      .bus_rw   (rw),
      .data_in  (data_in),
      .dma_grant(dma_grant),
      .dma_req  (dma_req)
   );

   bus_arbiter arbiter (
      .cpu_req  (cpu_req),
      .dma_req  (dma_req),
      .cpu_ready(cpu_ready),
      .dma_grant(dma_grant),
      .addr     (addr),
      .data_out (data_out),
      .rw       (rw)
   );

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
   input  cpu_pkg::bus_req_t cpu_req,
   input  cpu_pkg::bus_req_t dma_req,
   output logic              cpu_ready,
   output logic              dma_grant,
   output cpu_pkg::addr_t    addr,
   output cpu_pkg::data_t    data_out,
   output logic              rw
);

   cpu_pkg::bus_req_t winner;
   logic              writing;

   // DMA has fixed priority over the CPU
   assign dma_grant = dma_req.request;
   assign cpu_ready = cpu_req.request && !dma_req.request;

   assign winner = dma_grant ? dma_req : cpu_req;

   // an idle winner shows up as a read
   assign writing = winner.request && winner.write;

   assign addr     = winner.addr;
   assign rw       = !writing;
   assign data_out = writing ? winner.wdata : 8'h00;

   always_comb begin
      assert (!(dma_grant && cpu_ready))
         else $error("bus granted to both CPU and DMA");
   end

endmodule

// ==== logic/sprite_dma.sv ====
`timescale 1ns/1ps

module sprite_dma (
   input                     clock,
   input                     nreset,
   input  cpu_pkg::addr_t    bus_addr,
   input  cpu_pkg::data_t    bus_data,
   input  logic              bus_rw,
   input  cpu_pkg::data_t    data_in,
   input  logic              dma_grant,
   output cpu_pkg::bus_req_t dma_req
);

   logic           active;
   logic [8:0]     count;
   cpu_pkg::data_t page;
   cpu_pkg::data_t buffer;
   logic           trigger_write;
   logic           start;

   // write to the trigger address on the shared bus
   assign trigger_write = !bus_rw && (bus_addr == cpu_pkg::DMA_TRIGGER_ADDR);
   assign start         = trigger_write && !dma_grant;

   // even count reads the page, odd count writes the sprite port
   always_comb begin
      dma_req.request = active;
      dma_req.write   = count[0];
      dma_req.wdata   = buffer;
      if (count[0]) begin
         dma_req.addr = cpu_pkg::SPRITE_PORT_ADDR;
      end else begin
         dma_req.addr = {page, count[8:1]};
      end
   end

   always_ff @(posedge clock) begin
      if (nreset) begin
         active <= 1'b0;
         count  <= '0;
      end else if (active) begin
         if (dma_grant) begin
            count <= count + 9'd1;
            if (count == 9'h1ff) begin
               active <= 1'b0;
            end
         end
      end else if (start) begin
         active <= 1'b1;
         count  <= '0;
      end
   end

   // page number and the byte in flight
   always_ff @(posedge clock) begin
      if (start && !active) begin
         page <= bus_data;
      end
      if (active && dma_grant && !count[0]) begin
         buffer <= data_in;
      end
   end

   no_retrigger: assert property (
      @(posedge clock) disable iff (nreset)
      active |-> !trigger_write
   );

endmodule

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
   parameter cpu_pkg::addr_t RESET_PC = 16'h8000
) (
   input                     clock,
   input                     nreset,
   input  cpu_pkg::data_t    data_in,
   input  logic              cpu_ready,
   output cpu_pkg::bus_req_t cpu_req
);

   cpu_pkg::addr_t   pc;
   cpu_pkg::data_t   a_reg;
   cpu_pkg::flags_t  flags;
   cpu_pkg::opcode_u opcode;
   cpu_pkg::addr_t   addr_latch;
   logic [1:0]       step;

   cpu_pkg::alu_op_e alu_op;
   cpu_pkg::data_t   alu_result;
   cpu_pkg::flags_t  alu_flags;
   logic             alu_writes_a;

   logic             group_one;
   logic             is_sta;
   logic             mode_imm;
   logic             mode_abs;
   logic [1:0]       last_step;
   logic             exec;

   // decode straight from the opcode fields
   assign alu_op    = cpu_pkg::alu_op_e'(opcode.f.aaa);
   assign group_one = (opcode.f.cc == cpu_pkg::GROUP_ONE);
   assign is_sta    = (alu_op == cpu_pkg::ALU_STA);

   // no immediate STA, so that one falls to a no-op
   assign mode_imm = group_one && (opcode.f.bbb == cpu_pkg::MODE_IMM) && !is_sta;
   assign mode_abs = group_one && (opcode.f.bbb == cpu_pkg::MODE_ABS);

   always_comb begin
      if (mode_abs) begin
         last_step = 2'd3;
      end else begin
         last_step = 2'd1;
      end
   end

   // operand cycle, data_in holds the value for the ALU
   assign exec = ((step == 2'd1) && mode_imm) || ((step == 2'd3) && mode_abs);

   cpu_alu alu (
      .op       (alu_op),
      .a        (a_reg),
      .operand  (data_in),
      .flags_in (flags),
      .result   (alu_result),
      .flags_out(alu_flags),
      .writes_a (alu_writes_a)
   );

   // bus request for the current step
   always_comb begin
      cpu_req         = '0;
      cpu_req.request = 1'b1;
      cpu_req.addr    = pc;
      if (step == 2'd3) begin
         cpu_req.addr  = addr_latch;
         cpu_req.write = is_sta;
         cpu_req.wdata = is_sta ? a_reg : 8'h00;
      end
   end

   // control and architectural state
   always_ff @(posedge clock) begin
      if (nreset) begin
         pc    <= RESET_PC;
         a_reg <= '0;
         flags <= '0;
         step  <= 2'd0;
      end else if (cpu_ready) begin
         if (exec) begin
            if (alu_writes_a) begin
               a_reg <= alu_result;
            end
            flags <= alu_flags;
         end

         case (step)
            2'd0: begin
               pc   <= pc + 16'd1;
               step <= 2'd1;
            end
            2'd1: begin
               if (mode_imm) begin
                  pc   <= pc + 16'd1;
                  step <= 2'd0;
               end else if (mode_abs) begin
                  pc   <= pc + 16'd1;
                  step <= 2'd2;
               end else begin
                  // dummy read, pc stays put
                  step <= 2'd0;
               end
            end
            2'd2: begin
               pc   <= pc + 16'd1;
               step <= 2'd3;
            end
            default: begin
               step <= 2'd0;
            end
         endcase
      end
   end

   // opcode and address latch
   always_ff @(posedge clock) begin
      if (cpu_ready) begin
         if (step == 2'd0) begin
            opcode.raw <= data_in;
         end
         if ((step == 2'd1) && mode_abs) begin
            addr_latch[7:0] <= data_in;
         end
         if (step == 2'd2) begin
            addr_latch[15:8] <= data_in;
         end
      end
   end

   // past the opcode fetch, the step stays within the decoded mode
   step_in_mode: assert property (
      @(posedge clock) disable iff (nreset)
      (step != 2'd0) |-> (step <= last_step)
   );

endmodule

// ==== logic/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
   input  cpu_pkg::alu_op_e op,
   input  cpu_pkg::data_t   a,
   input  cpu_pkg::data_t   operand,
   input  cpu_pkg::flags_t  flags_in,
   output cpu_pkg::data_t   result,
   output cpu_pkg::flags_t  flags_out,
   output logic             writes_a
);

   logic           subtract;
   logic           carry_in;
   cpu_pkg::data_t addend;
   logic [8:0]     sum;
   logic           overflow;

   // SBC and CMP add the inverted operand
   assign subtract = (op == cpu_pkg::ALU_SBC) || (op == cpu_pkg::ALU_CMP);
   assign addend   = subtract ? ~operand : operand;

   // CMP ignores the carry and always adds one
   assign carry_in = (op == cpu_pkg::ALU_CMP) ? 1'b1 : flags_in.c;

   assign sum = {1'b0, a} + {1'b0, addend} + {8'd0, carry_in};

   // signed overflow when both inputs share a sign the sum does not
   assign overflow = (a[7] == addend[7]) && (sum[7] != a[7]);

   always_comb begin
      result    = a;
      flags_out = flags_in;
      writes_a  = 1'b1;

      case (op)
         cpu_pkg::ALU_ORA: result = a | operand;
         cpu_pkg::ALU_AND: result = a & operand;
         cpu_pkg::ALU_EOR: result = a ^ operand;
         cpu_pkg::ALU_ADC,
         cpu_pkg::ALU_SBC: begin
            result      = sum[7:0];
            flags_out.c = sum[8];
            flags_out.v = overflow;
         end
         cpu_pkg::ALU_STA: begin
            // A goes out on the bus, nothing changes here
            writes_a = 1'b0;
         end
         cpu_pkg::ALU_LDA: result = operand;
         cpu_pkg::ALU_CMP: begin
            // difference only feeds the flags
            result      = sum[7:0];
            flags_out.c = sum[8];
            writes_a    = 1'b0;
         end
      endcase

      // N and Z follow the result for all but STA
      if (op != cpu_pkg::ALU_STA) begin
         flags_out.n = result[7];
         flags_out.z = (result == 8'h00);
      end
   end

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   // group one opcode layout is aaa_bbb_cc
   typedef struct packed {
      logic [2:0] aaa;
      logic [2:0] bbb;
      logic [1:0] cc;
   } opcode_fields_t;

   // the fetched opcode, as a byte or split into its fields
   typedef union packed {
      data_t          raw;
      opcode_fields_t f;
   } opcode_u;

   // one peer's request for the shared bus
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  write;
      logic  request;
   } bus_req_t;

   // order follows the aaa field
   typedef enum logic [2:0] {
      ALU_ORA = 3'd0,
      ALU_AND = 3'd1,
      ALU_EOR = 3'd2,
      ALU_ADC = 3'd3,
      ALU_STA = 3'd4,
      ALU_LDA = 3'd5,
      ALU_CMP = 3'd6,
      ALU_SBC = 3'd7
   } alu_op_e;

   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } flags_t;

   // writing here starts a sprite DMA
   localparam addr_t DMA_TRIGGER_ADDR = 16'h4014;
   // OAM data port
   localparam addr_t SPRITE_PORT_ADDR = 16'h2004;

   // bbb values for the two supported modes
   localparam logic [2:0] MODE_IMM = 3'b010;
   localparam logic [2:0] MODE_ABS = 3'b011;

   localparam logic [1:0] GROUP_ONE = 2'b01;

endpackage
